// ==== include/conv_params.svh ====
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// ==============================
// Array and tile geometry
// ==============================
`define CONV_ARRAY_SIZE 8                                     // Systolic edge, result beats per tile
`define CONV_TILE_ELEMS (`CONV_ARRAY_SIZE * `CONV_ARRAY_SIZE) // Input beats per tile

// ==============================
// Legal job configuration
// ==============================
`define CONV_MIN_N 16 // Input dimension range
`define CONV_MAX_N 64
`define CONV_MIN_K 2  // Kernel dimension range
`define CONV_MAX_K 16

`endif

// ==== design/conv_pkg.sv ====
package conv_pkg;

    // ==============================
    // Widths with a meaning
    // ==============================
    typedef logic [6:0]  dim_n_t;     // Input dimension N
    typedef logic [4:0]  dim_k_t;     // Kernel dimension K
    typedef logic [11:0] elems_t;     // Output elements (N-K+1)^2
    typedef logic [15:0] beat_cnt_t;  // Stream beats, weight counts
    typedef logic [15:0] cycle_cnt_t; // Profiling counter

    // Job phases
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        LOAD_WEIGHTS = 3'd1, // K*K weight beats
        LOAD_INPUT   = 3'd2, // One tile of input beats
        COMPUTE      = 3'd3, // Wait for array
        DRAIN        = 3'd4, // One tile of results out
        DONE         = 3'd5  // Single-cycle done
    } conv_state_e;

    // Latched job configuration and derived totals
    typedef struct packed {
        dim_n_t    n;
        dim_k_t    k;
        beat_cnt_t weight_total; // K*K
        elems_t    output_total; // (N-K+1)^2
    } conv_cfg_t;

    // Array and memory strobes
    typedef struct packed {
        logic sa_enable;      // MAC enable
        logic sa_clear;       // Accumulator clear
        logic sa_load_weight; // Weight shift into PEs
        logic mem_write_en;
        logic mem_read_en;
        logic bank_sel;       // Ping-pong input bank
    } array_ctrl_t;

endpackage

// ==== design/conv_cfg_latch.sv ====
`timescale 1ns/1ps

`include "conv_params.svh"

module conv_cfg_latch
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_accept, // Start seen in IDLE
    input  dim_n_t    cfg_n,
    input  dim_k_t    cfg_k,
    output conv_cfg_t cfg
);

    dim_n_t    out_dim;   // N-K+1
    conv_cfg_t cfg_next;

    // ==============================
    // Totals from the raw inputs
    // ==============================
    always_comb begin
        out_dim               = cfg_n - dim_n_t'(cfg_k) + dim_n_t'(1);
        cfg_next.n            = cfg_n;
        cfg_next.k            = cfg_k;
        cfg_next.weight_total = beat_cnt_t'(cfg_k) * beat_cnt_t'(cfg_k); // Max 256
        cfg_next.output_total = elems_t'(out_dim) * elems_t'(out_dim);   // Max 63*63
    end

    // Sampled on the accepting edge, valid next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (start_accept) begin
            cfg <= cfg_next;
        end
    end

    // Host must offer a legal job when the start is taken
    a_cfg_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        start_accept |-> (cfg_n >= `CONV_MIN_N) && (cfg_n <= `CONV_MAX_N) &&
                         (cfg_k >= `CONV_MIN_K) && (cfg_k <= `CONV_MAX_K) &&
                         (dim_n_t'(cfg_k) <= cfg_n)
    ) else $error("Start accepted with out-of-range N=%0d K=%0d", cfg_n, cfg_k);

endmodule

// ==== design/conv_load_counter.sv ====
`timescale 1ns/1ps

`include "conv_params.svh"

module conv_load_counter
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rx_valid,
    input  logic        rx_ready,
    input  conv_state_e state,
    input  conv_cfg_t   cfg,
    output logic        load_last // Beat that completes the phase
);

    beat_cnt_t beat_cnt;  // Beats taken so far in this phase
    beat_cnt_t last_idx;  // Index of the final beat
    logic      rx_accept;
    logic      in_load;

    // ==============================
    // Phase target and last-beat flag
    // ==============================
    always_comb begin
        rx_accept = rx_valid && rx_ready;
        in_load   = (state == LOAD_WEIGHTS) || (state == LOAD_INPUT);
        if (state == LOAD_WEIGHTS) begin
            last_idx = cfg.weight_total - beat_cnt_t'(1);
        end else begin
            last_idx = beat_cnt_t'(`CONV_TILE_ELEMS - 1); // One input tile
        end
        load_last = in_load && rx_accept && (beat_cnt == last_idx);
    end

    // Count wraps to zero on the same edge the phase ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (!in_load || load_last) begin
            beat_cnt <= '0;
        end else if (rx_accept) begin
            beat_cnt <= beat_cnt + beat_cnt_t'(1);
        end
    end

    // Receive handshake belongs to the load phases only
    a_rx_in_load : assert property (
        @(posedge clk) disable iff (!rst_n)
        (rx_valid && rx_ready) |-> in_load
    ) else $error("Receive beat accepted in state %s", state.name());

endmodule

// ==== design/conv_drain_counter.sv ====
`timescale 1ns/1ps

`include "conv_params.svh"

module conv_drain_counter
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_valid,
    input  logic        tx_ready,
    input  conv_state_e state,
    input  conv_cfg_t   cfg,
    output logic        tile_last, // 8th result beat of a tile
    output logic        job_last   // Same beat, job output complete
);

    localparam int TILE_W = $clog2(`CONV_ARRAY_SIZE);
    localparam logic [TILE_W-1:0] TILE_END = TILE_W'(`CONV_ARRAY_SIZE - 1);

    logic [TILE_W-1:0] tile_cnt; // Beats within the tile
    beat_cnt_t         out_cnt;  // Results sent this job
    beat_cnt_t         out_nxt;  // Count including this beat
    logic              tx_accept;

    // ==============================
    // End-of-tile and end-of-job flags
    // ==============================
    always_comb begin
        tx_accept = tx_valid && tx_ready;
        out_nxt   = out_cnt + beat_cnt_t'(1);
        tile_last = tx_accept && (tile_cnt == TILE_END);
        job_last  = tile_last && (out_nxt >= beat_cnt_t'(cfg.output_total)); // Last tile may overshoot
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_cnt <= '0;
            out_cnt  <= '0;
        end else if (state == IDLE) begin
            tile_cnt <= '0;   // Fresh job
            out_cnt  <= '0;
        end else if (tx_accept) begin
            tile_cnt <= tile_last ? '0 : tile_cnt + 1'b1;
            out_cnt  <= out_nxt;
        end
    end

    // Results only leave while draining
    a_tx_in_drain : assert property (
        @(posedge clk) disable iff (!rst_n)
        (tx_valid && tx_ready) |-> (state == DRAIN)
    ) else $error("Transmit beat accepted in state %s", state.name());

endmodule

// ==== design/conv_sequencer.sv ====
`timescale 1ns/1ps

module conv_sequencer
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,        // Host start pulse
    input  logic        sa_done,      // Array finished the tile
    input  logic        load_last,
    input  logic        tile_last,
    input  logic        job_last,
    output conv_state_e state,
    output logic        start_accept,
    output logic        rx_ready,
    output logic        tx_valid,
    output logic        done,
    output cycle_cnt_t  cycle_count
);

    conv_state_e next_state;

    // ==============================
    // Phase register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ==============================
    // Next phase
    // ==============================
    always_comb begin
        next_state = state; // Hold by default
        case (state)
            IDLE: begin
                if (start) next_state = LOAD_WEIGHTS;
            end
            LOAD_WEIGHTS: begin
                if (load_last) next_state = LOAD_INPUT;  // All K*K weights in
            end
            LOAD_INPUT: begin
                if (load_last) next_state = COMPUTE;     // Tile complete
            end
            COMPUTE: begin
                if (sa_done) next_state = DRAIN;
            end
            DRAIN: begin
                if (tile_last) begin
                    // Either wrap up or fetch the next tile
                    next_state = job_last ? DONE : LOAD_INPUT;
                end
            end
            DONE:    next_state = IDLE; // One-cycle pulse
            default: next_state = IDLE;
        endcase
    end

    // Handshakes decoded straight from the phase
    always_comb begin
        start_accept = (state == IDLE) && start;
        rx_ready     = (state == LOAD_WEIGHTS) || (state == LOAD_INPUT);
        tx_valid     = (state == DRAIN);
        done         = (state == DONE);
    end

    // ==============================
    // Profiling counter
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else if (start_accept) begin
            cycle_count <= '0;                           // New job
        end else if ((state != IDLE) && (state != DONE)) begin
            cycle_count <= cycle_count + cycle_cnt_t'(1); // Active cycles only
        end
    end

    // Counter flags only arrive in the phase that owns their stream
    a_flags_in_phase : assert property (
        @(posedge clk) disable iff (!rst_n)
        (!load_last || rx_ready) && (!tile_last || tx_valid) && (!job_last || tile_last)
    ) else $error("Counter flag outside its stream phase in state %s", state.name());

endmodule

// ==== design/conv_array_ctrl.sv ====
`timescale 1ns/1ps

module conv_array_ctrl
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rx_valid,
    input  logic        rx_ready,
    input  conv_state_e state,
    output array_ctrl_t ctrl // All fields one cycle behind the phase
);

    conv_state_e prev_state; // Phase seen last cycle
    logic        first_tile; // Still on tile 0 of the job
    logic        rx_accept;
    logic        li_entry;   // First cycle of LOAD_INPUT
    array_ctrl_t ctrl_d;

    // ==============================
    // Next strobe values
    // ==============================
    always_comb begin
        rx_accept = rx_valid && rx_ready;
        li_entry  = (state == LOAD_INPUT) && (prev_state != LOAD_INPUT);

        ctrl_d.sa_load_weight = (state == LOAD_WEIGHTS) && rx_accept; // One per weight
        ctrl_d.mem_write_en   = rx_accept;                            // One per received beat
        ctrl_d.mem_read_en    = (state == COMPUTE) || (state == DRAIN);
        ctrl_d.sa_enable      = (state == COMPUTE);
        ctrl_d.sa_clear       = (state == IDLE) || ((state == LOAD_INPUT) && first_tile);

        // Ping-pong bank, tile 0 always lands in bank 0
        if (state == IDLE) begin
            ctrl_d.bank_sel = 1'b0;
        end else if (li_entry) begin
            ctrl_d.bank_sel = first_tile ? 1'b0 : ~ctrl.bank_sel;
        end else begin
            ctrl_d.bank_sel = ctrl.bank_sel;
        end
    end

    // ==============================
    // Output and tracking registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl          <= '0;
            ctrl.sa_clear <= 1'b1;  // Accumulators held clear out of reset
            prev_state    <= IDLE;
            first_tile    <= 1'b1;
        end else begin
            ctrl       <= ctrl_d;
            prev_state <= state;
            if (state == IDLE) begin
                first_tile <= 1'b1;
            end else if (state == DRAIN) begin
                first_tile <= 1'b0; // Tile 0 results going out
            end
        end
    end

endmodule

// ==== design/conv_ctrl_top.sv ====
`timescale 1ns/1ps

module conv_ctrl_top
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  dim_n_t      cfg_n,
    input  dim_k_t      cfg_k,
    input  logic        rx_valid,
    input  logic        tx_ready,
    input  logic        sa_done,
    output logic        done,
    output logic        rx_ready,
    output logic        tx_valid,
    output array_ctrl_t array_ctrl,
    output cycle_cnt_t  cycle_count
);

    conv_state_e state;
    conv_cfg_t   cfg;
    logic        start_accept;
    logic        load_last;
    logic        tile_last;
    logic        job_last;

    // ==============================
    // Phase FSM and host side
    // ==============================
    conv_sequencer i_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .sa_done      (sa_done),
        .load_last    (load_last),
        .tile_last    (tile_last),
        .job_last     (job_last),
        .state        (state),
        .start_accept (start_accept),
        .rx_ready     (rx_ready),
        .tx_valid     (tx_valid),
        .done         (done),
        .cycle_count  (cycle_count)
    );

    conv_cfg_latch i_cfg_latch (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_accept (start_accept),
        .cfg_n        (cfg_n),
        .cfg_k        (cfg_k),
        .cfg          (cfg)
    );

    // Stream beat counters
    conv_load_counter i_load_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .state     (state),
        .cfg       (cfg),
        .load_last (load_last)
    );

    conv_drain_counter i_drain_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .state     (state),
        .cfg       (cfg),
        .tile_last (tile_last),
        .job_last  (job_last)
    );

    conv_array_ctrl i_array_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .state    (state),
        .ctrl     (array_ctrl)
    );

endmodule

// ==== tests/conv_ctrl_tb.sv ====
`timescale 1ns/1ps

`include "conv_params.svh"

module conv_ctrl_tb
    import conv_pkg::*;
();

    localparam int NUM_JOBS = 8;
    localparam int TILE_IN  = `CONV_TILE_ELEMS; // Input beats per tile
    localparam int TILE_OUT = `CONV_ARRAY_SIZE; // Result beats per tile

    logic        clk;
    logic        rst_n;
    logic        start;
    dim_n_t      cfg_n;
    dim_k_t      cfg_k;
    logic        rx_valid;
    logic        tx_ready;
    logic        sa_done;
    logic        done;
    logic        rx_ready;
    logic        tx_valid;
    array_ctrl_t array_ctrl;
    cycle_cnt_t  cycle_count;

    logic [31:0] rng = 32'h446b5a92; // xorshift state
    int          job_n [NUM_JOBS];
    int          job_k [NUM_JOBS];
    int          cycle_limit = 0;      // Zero until the jobs are drawn
    int          cycle_total = 0;
    int          errors = 0;
    int          kk;                   // Weight beats of the running job
    int          exp_rx;
    int          exp_tx;
    int          rx_cnt;
    int          tx_cnt;
    int          lw_cnt;               // sa_load_weight cycles
    int          wr_cnt;               // mem_write_en cycles
    int          sa_delay;             // Cycles until sa_done
    int          mid_edge;             // Edge of the stray start
    dim_n_t      alt_n;
    dim_k_t      alt_k;

    conv_ctrl_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg_n       (cfg_n),
        .cfg_k       (cfg_k),
        .rx_valid    (rx_valid),
        .tx_ready    (tx_ready),
        .sa_done     (sa_done),
        .done        (done),
        .rx_ready    (rx_ready),
        .tx_valid    (tx_valid),
        .array_ctrl  (array_ctrl),
        .cycle_count (cycle_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_total = cycle_total + 1;
        if (cycle_limit > 0 && cycle_total > cycle_limit) begin
            $display("TESTBENCH FAILED");
            $display("Timeout: the DUT did not finish all jobs within %0d cycles", cycle_limit);
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    // ==============================
    // Random numbers and model
    // ==============================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int rand_below(input int unsigned m);
        rng = xorshift32(rng);
        return int'(rng % m);
    endfunction

    function automatic int tiles_for(input int n, input int k);
        int o;
        o = (n - k + 1) * (n - k + 1);     // Output elements
        return (o + TILE_OUT - 1) / TILE_OUT; // Partial last tile still drains fully
    endfunction

    // ==============================
    // Error reporting and compares
    // ==============================
    task automatic fail_run(input string what);
        errors++;
        $display("TESTBENCH FAILED");
        $display("%s", what);
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compare_beats(input string name, input beat_cnt_t exp, input beat_cnt_t got);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got));
        end
    endtask

    task automatic compare_cycles(input string name, input cycle_cnt_t exp, input cycle_cnt_t got);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got));
        end
    endtask

    task automatic compare_ctrl(input string name, input array_ctrl_t exp, input array_ctrl_t got);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    // ==============================
    // Per-cycle drive and observe
    // ==============================
    task automatic drive_cycle(input int edge_no);
        rx_valid <= (rand_below(3) != 0); // Low about a third of the time
        tx_ready <= (rand_below(3) != 0);
        start    <= (edge_no == mid_edge); // Stray start, must be ignored
        if (edge_no == mid_edge) begin
            cfg_n <= alt_n;
            cfg_k <= alt_k;
        end
        if (sa_delay > 0) begin
            sa_delay--;
            sa_done <= (sa_delay == 0);
        end else begin
            sa_done <= 1'b0;
        end
    endtask

    // Sampled mid-cycle, handshakes seen here land on the next edge
    task automatic sample_cycle(output logic job_end);
        int tile;
        if (rx_valid && rx_ready) begin
            compare_bit("tx_valid during rx beat", 1'b0, tx_valid);
            tile = (rx_cnt < kk) ? 0 : (rx_cnt - kk) / TILE_IN;
            compare_beats("tx beats before rx beat", beat_cnt_t'(TILE_OUT * tile),
                          beat_cnt_t'(tx_cnt));
            rx_cnt++;
            if (rx_cnt > kk && (rx_cnt - kk) % TILE_IN == 0) begin
                sa_delay = 1 + rand_below(10); // Array busy 1..10 cycles
            end
        end
        if (tx_valid && tx_ready) begin
            compare_beats("rx beats before tx beat",
                          beat_cnt_t'(kk + TILE_IN * (tx_cnt / TILE_OUT + 1)),
                          beat_cnt_t'(rx_cnt));
            tx_cnt++;
        end
        if (array_ctrl.sa_load_weight) lw_cnt++;
        if (array_ctrl.mem_write_en) begin
            if (wr_cnt >= kk && (wr_cnt - kk) % TILE_IN == 0) begin
                tile = (wr_cnt - kk) / TILE_IN; // First write of a tile
                compare_bit("bank_sel", tile[0], array_ctrl.bank_sel);
            end
            wr_cnt++;
        end
        job_end = done;
    endtask

    task automatic run_job(input int j);
        int   edges;
        logic job_end;
        kk       = job_k[j] * job_k[j];
        exp_tx   = TILE_OUT * tiles_for(job_n[j], job_k[j]);
        exp_rx   = kk + TILE_IN * tiles_for(job_n[j], job_k[j]);
        rx_cnt   = 0;
        tx_cnt   = 0;
        lw_cnt   = 0;
        wr_cnt   = 0;
        sa_delay = 0;
        mid_edge = 3 + rand_below(28);
        alt_n    = dim_n_t'((job_n[j] == 32) ? 16 : job_n[j] + 1);
        alt_k    = dim_k_t'((job_k[j] == 2) ? 3 : job_k[j] - 1);
        @(posedge clk);
        start <= 1'b1;
        cfg_n <= dim_n_t'(job_n[j]);
        cfg_k <= dim_k_t'(job_k[j]);
        @(posedge clk); // Accepting edge
        edges = 0;
        drive_cycle(edges);
        job_end = 1'b0;
        while (!job_end) begin
            @(negedge clk);
            sample_cycle(job_end);
            if (!job_end) begin
                @(posedge clk);
                edges++;
                drive_cycle(edges);
            end
        end
        compare_beats("rx beats", beat_cnt_t'(exp_rx), beat_cnt_t'(rx_cnt));
        compare_beats("tx beats", beat_cnt_t'(exp_tx), beat_cnt_t'(tx_cnt));
        compare_beats("sa_load_weight pulses", beat_cnt_t'(kk), beat_cnt_t'(lw_cnt));
        compare_beats("mem_write_en pulses", beat_cnt_t'(exp_rx), beat_cnt_t'(wr_cnt));
        compare_cycles("cycle_count", cycle_cnt_t'(edges), cycle_count);
        @(posedge clk);
        drive_cycle(-1);
        @(negedge clk);
        compare_bit("done after pulse", 1'b0, done); // Single-cycle pulse
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int          limit_sum;
        array_ctrl_t ctrl_rst;
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg_n    = '0;
        cfg_k    = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        sa_done  = 1'b0;
        limit_sum = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_n[j] = 16 + rand_below(17); // N in 16..32
            job_k[j] = 2 + rand_below(15);  // K in 2..16
            limit_sum += job_k[j] * job_k[j]
                         + (TILE_IN + TILE_OUT) * tiles_for(job_n[j], job_k[j]) + 20;
        end
        cycle_limit = 4 * limit_sum;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        ctrl_rst          = '0;
        ctrl_rst.sa_clear = 1'b1;
        compare_bit("done at reset", 1'b0, done);
        compare_bit("rx_ready at reset", 1'b0, rx_ready);
        compare_bit("tx_valid at reset", 1'b0, tx_valid);
        compare_ctrl("array_ctrl at reset", ctrl_rst, array_ctrl);
        compare_cycles("cycle_count at reset", '0, cycle_count);
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
design/conv_pkg.sv
design/conv_cfg_latch.sv
design/conv_load_counter.sv
design/conv_drain_counter.sv
design/conv_sequencer.sv
design/conv_array_ctrl.sv
design/conv_ctrl_top.sv
tests/conv_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: conv_ctrl

export_include_dirs:
  - include

sources:
  - design/conv_pkg.sv
  - design/conv_cfg_latch.sv
  - design/conv_load_counter.sv
  - design/conv_drain_counter.sv
  - design/conv_sequencer.sv
  - design/conv_array_ctrl.sv
  - design/conv_ctrl_top.sv
  - target: test
    files:
      - tests/conv_ctrl_tb.sv
